//--- dv/line_mover_tb.sv
`default_nettype none

`include "sysbus_defs.svh"

module line_mover_tb;
    localparam int LW = `SYSBUS_LINE_WIDTH;
    localparam int DW = `SYSBUS_DATA_WIDTH;
    localparam int TW = `SYSBUS_TAG_WIDTH;
    localparam int LO = `SYSBUS_LINE_OFFSET;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [TW-1:0] WRITE_TAG = {`SYSBUS_WRITE, `SYSBUS_MEMORY, 8'h00};
    localparam logic [TW-1:0] READ_TAG = {`SYSBUS_READ, `SYSBUS_MEMORY, 8'h00};

    logic clk;
    logic reset;
    logic store_enable;
    logic [DW-1:0] store_addr;
    logic [LW-1:0] store_line;
    logic fetch_enable;
    logic [DW-1:0] fetch_addr;
    logic bus_reqack;
    logic bus_respcyc;
    logic [DW-1:0] bus_resp;
    logic store_ready;
    logic fetch_ready;
    logic [LW-1:0] fetch_line;
    logic bus_reqcyc;
    logic [DW-1:0] bus_req;
    logic [TW-1:0] bus_reqtag;
    logic bus_respack;
    logic bus_busy;

    integer seed;
    logic [31:0] region;
    string test_name;
    int tests;
    int checks;
    int errors;
    int test_checks;
    int test_errors;
    bit timed_out;
    logic prev_busy;
    logic prev_owner;
    logic [TW+DW-1:0] store_beats[$];
    logic [TW+DW-1:0] fetch_beats[$];
    logic cmd_order[$];
    logic [LW-1:0] model [logic [DW-1:0]];
    logic [DW-1:0] stored_keys[$];

    line_mover u_line_mover
    (
        .clk(clk), .reset(reset), .store_enable(store_enable), .store_addr(store_addr),
        .store_line(store_line), .fetch_enable(fetch_enable), .fetch_addr(fetch_addr),
        .bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc), .bus_resp(bus_resp),
        .store_ready(store_ready), .fetch_ready(fetch_ready), .fetch_line(fetch_line),
        .bus_reqcyc(bus_reqcyc), .bus_req(bus_req), .bus_reqtag(bus_reqtag),
        .bus_respack(bus_respack), .bus_busy(bus_busy)
    );

    sysbus_mem #(.SEED(32'h856b0703)) u_sysbus_mem
    (
        .clk(clk), .reset(reset), .reqcyc(bus_reqcyc), .req(bus_req), .reqtag(bus_reqtag),
        .respack(bus_respack), .reqack(bus_reqack), .respcyc(bus_respcyc), .resp(bus_resp)
    );

    always #5 clk = ~clk;

    task automatic check(input string what, input logic [LW-1:0] expected,
        input logic [LW-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // request beats are sorted by command with their order kept, and the owner may not
    // change inside a busy period.
    always @(posedge clk)
    begin
        if (reset)
            prev_busy <= 1'b0;
        else
        begin
            if (bus_reqcyc && bus_reqack)
            begin
                cmd_order.push_back(bus_reqtag[TW-1]);
                if (bus_reqtag[TW-1] == `SYSBUS_WRITE)
                    store_beats.push_back({bus_reqtag, bus_req});
                else
                    fetch_beats.push_back({bus_reqtag, bus_req});
            end
            if (prev_busy && bus_busy)
                check("bus owner while busy", LW'(prev_owner), LW'(u_line_mover.owner));
            prev_busy <= bus_busy;
            prev_owner <= u_line_mover.owner;
        end
    end

    function automatic logic [DW-1:0] line_base(input logic [DW-1:0] a);
        return {a[DW-1:LO], {LO{1'b0}}};
    endfunction

    function automatic logic [LW-1:0] random_line();
        logic [LW-1:0] v;
        int i;
        v = '0;
        for (i = 0; i < LW / 32; i++)
            v[i*32 +: 32] = $random(seed);
        return v;
    endfunction

    // addresses share one random region so that later stores overwrite earlier lines.
    function automatic logic [DW-1:0] random_addr();
        logic [31:0] r;
        r = $random(seed);
        return {region, 20'h0, r[11:0]};
    endfunction

    function automatic logic [DW-1:0] pick_stored();
        logic [31:0] r;
        logic [31:0] low;
        int idx;
        r = $random(seed);
        low = $random(seed);
        idx = int'(r % stored_keys.size());
        return {stored_keys[idx][DW-1:LO], low[LO-1:0]};
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
            errors - test_errors);
    endtask

    task automatic launch(input bit do_store, input bit do_fetch, input logic [DW-1:0] saddr,
        input logic [LW-1:0] sline, input logic [DW-1:0] faddr);
        cmd_order.delete();
        @(posedge clk);
        if (do_store)
        begin
            store_enable <= 1'b1;
            store_addr <= saddr;
            store_line <= sline;
        end
        if (do_fetch)
        begin
            fetch_enable <= 1'b1;
            fetch_addr <= faddr;
        end
        @(posedge clk);
        store_enable <= 1'b0;
        fetch_enable <= 1'b0;
    endtask

    task automatic wait_ready(input bit want_store, input bit want_fetch, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++)
        begin
            @(posedge clk);
            ok = (!want_store || store_ready) && (!want_fetch || fetch_ready);
        end
        if (!ok)
        begin
            $display("%s: ready did not rise within %0d cycles", test_name, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_store(input logic [DW-1:0] addr, input logic [LW-1:0] line);
        logic [TW+DW-1:0] beat;
        logic [DW-1:0] base;
        int i;
        base = line_base(addr);
        check("store beat count", LW'(`SYSBUS_LINE_BEATS + 1), LW'(store_beats.size()));
        for (i = 0; i <= `SYSBUS_LINE_BEATS && store_beats.size() != 0; i++)
        begin
            beat = store_beats.pop_front();
            check("store tag", LW'(WRITE_TAG), LW'(beat[TW+DW-1:DW]));
            if (i == 0)
                check("store address", LW'(base), LW'(beat[DW-1:0]));
            else
                check($sformatf("store word %0d", i - 1), LW'(line[(i-1)*DW +: DW]),
                    LW'(beat[DW-1:0]));
        end
        store_beats.delete();
        if (!model.exists(base))
            stored_keys.push_back(base);
        model[base] = line;
    endtask

    task automatic check_fetch(input logic [DW-1:0] addr);
        logic [TW+DW-1:0] beat;
        logic [DW-1:0] base;
        base = line_base(addr);
        check("fetch beat count", LW'(1), LW'(fetch_beats.size()));
        if (fetch_beats.size() != 0)
        begin
            beat = fetch_beats.pop_front();
            check("fetch tag", LW'(READ_TAG), LW'(beat[TW+DW-1:DW]));
            check("fetch address", LW'(base), LW'(beat[DW-1:0]));
        end
        fetch_beats.delete();
        if (model.exists(base))
            check("fetch line", model[base], fetch_line);
    endtask

    task automatic store_once(input logic [DW-1:0] addr, input logic [LW-1:0] line);
        bit ok;
        launch(1'b1, 1'b0, addr, line, '0);
        wait_ready(1'b1, 1'b0, ok);
        if (ok)
            check_store(addr, line);
    endtask

    task automatic fetch_once(input logic [DW-1:0] addr);
        bit ok;
        launch(1'b0, 1'b1, '0, '0, addr);
        wait_ready(1'b0, 1'b1, ok);
        if (ok)
            check_fetch(addr);
    endtask

    initial
    begin
        bit ok;
        logic [DW-1:0] saddr;
        logic [DW-1:0] faddr;
        logic [LW-1:0] sline;
        logic first_cmd;
        int n;
        seed = 32'h856b0703;
        clk = 1'b0;
        reset = 1'b1;
        store_enable = 1'b0;
        store_addr = '0;
        store_line = '0;
        fetch_enable = 1'b0;
        fetch_addr = '0;
        tests = 0;
        checks = 0;
        errors = 0;
        timed_out = 1'b0;
        region = $random(seed);

        begin_test("reset");
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check("bus_reqcyc", LW'(1'b0), LW'(bus_reqcyc));
        check("bus_respack", LW'(1'b0), LW'(bus_respack));
        check("bus_busy", LW'(1'b0), LW'(bus_busy));
        check("store_ready", LW'(1'b0), LW'(store_ready));
        check("fetch_ready", LW'(1'b0), LW'(fetch_ready));
        end_test();

        begin_test("store_beats");
        saddr = random_addr();
        sline = random_line();
        store_once(saddr, sline);
        end_test();

        begin_test("store_then_fetch");
        if (!timed_out)
            fetch_once(saddr ^ 64'h15);
        end_test();

        begin_test("back_pressure");
        for (n = 0; n < 40 && !timed_out; n++)
        begin
            saddr = random_addr();
            sline = random_line();
            store_once(saddr, sline);
            if (!timed_out)
                fetch_once(pick_stored());
        end
        end_test();

        // a lone fetch or store before each round sets the last owner, so the tie goes
        // to the store in even rounds and to the fetch in odd ones.
        begin_test("concurrent");
        for (n = 0; n < 4 && !timed_out; n++)
        begin
            if (n % 2 == 0)
            begin
                fetch_once(pick_stored());
                first_cmd = `SYSBUS_WRITE;
            end
            else
            begin
                saddr = random_addr();
                sline = random_line();
                store_once(saddr, sline);
                first_cmd = `SYSBUS_READ;
            end
            if (!timed_out)
            begin
                faddr = pick_stored();
                saddr = random_addr();
                if (line_base(saddr) == line_base(faddr))
                    saddr = saddr ^ 64'h40;
                sline = random_line();
                launch(1'b1, 1'b1, saddr, sline, faddr);
                wait_ready(1'b1, 1'b1, ok);
                if (ok)
                begin
                    if (cmd_order.size() != 0)
                        check("first grant", LW'(first_cmd), LW'(cmd_order[0]));
                    check_fetch(faddr);
                    check_store(saddr, sline);
                end
            end
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sysbus_mem.sv
`default_nettype none

`include "sysbus_defs.svh"

module sysbus_mem
#(
    parameter logic [31:0] SEED = 32'h856b0703
)
(
    input wire clk,
    input wire reset,
    input wire reqcyc,
    input wire [`SYSBUS_DATA_WIDTH-1:0] req,
    input wire [`SYSBUS_TAG_WIDTH-1:0] reqtag,
    input wire respack,
    output logic reqack,
    output logic respcyc,
    output logic [`SYSBUS_DATA_WIDTH-1:0] resp
);
    logic [`SYSBUS_LINE_WIDTH-1:0] lines [logic [`SYSBUS_DATA_WIDTH-1:0]];
    logic [`SYSBUS_LINE_WIDTH-1:0] wr_buf;
    logic [`SYSBUS_DATA_WIDTH-1:0] wr_base;
    logic [`SYSBUS_DATA_WIDTH-1:0] rd_base;
    logic [3:0] wr_left;
    logic [3:0] rd_left;
    logic [2:0] wr_idx;
    logic [2:0] rd_idx;
    integer seed;

    // a line that was never written reads back as a pattern built from its full address.
    function automatic logic [`SYSBUS_DATA_WIDTH-1:0] read_word(
        input logic [`SYSBUS_DATA_WIDTH-1:0] base, input logic [2:0] idx);
        logic [`SYSBUS_LINE_WIDTH-1:0] data;
        if (!lines.exists(base))
            return {base[`SYSBUS_DATA_WIDTH-1:`SYSBUS_LINE_OFFSET], idx, 3'b000}
                ^ 64'h6c3a_95e1_0f27_d4b8;
        data = lines[base];
        return data[idx*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH];
    endfunction

    initial
    begin
        seed = SEED;
        reqack = 1'b0;
        respcyc = 1'b0;
        resp = '0;
    end

    always @(posedge clk)
    begin : bus_side
        logic [`SYSBUS_LINE_WIDTH-1:0] full;
        logic [3:0] left;
        logic [2:0] idx;
        if (reset)
        begin
            reqack <= 1'b0;
            respcyc <= 1'b0;
            wr_left <= 4'd0;
            rd_left <= 4'd0;
        end
        else
        begin
            // a response beat holds until respack and may be followed by an idle gap.
            left = rd_left;
            idx = rd_idx;
            if (respcyc && respack)
            begin
                left = left - 4'd1;
                idx = idx + 3'd1;
            end
            if (!respcyc || respack)
            begin
                if (left != 4'd0 && ($random(seed) & 1) != 0)
                begin
                    respcyc <= 1'b1;
                    resp <= read_word(rd_base, idx);
                end
                else
                    respcyc <= 1'b0;
            end
            rd_left <= left;
            rd_idx <= idx;

            reqack <= ($random(seed) & 3) != 0;
            if (reqcyc && reqack)
            begin
                if (wr_left != 4'd0)
                begin
                    full = wr_buf;
                    full[wr_idx*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] = req;
                    wr_buf <= full;
                    wr_idx <= wr_idx + 3'd1;
                    wr_left <= wr_left - 4'd1;
                    if (wr_left == 4'd1)
                        lines[wr_base] = full;
                end
                else if (reqtag[`SYSBUS_TAG_WIDTH-1] == `SYSBUS_WRITE)
                begin
                    wr_base <= {req[`SYSBUS_DATA_WIDTH-1:`SYSBUS_LINE_OFFSET],
                        {`SYSBUS_LINE_OFFSET{1'b0}}};
                    wr_idx <= 3'd0;
                    wr_left <= 4'd8;
                end
                else
                begin
                    rd_base <= {req[`SYSBUS_DATA_WIDTH-1:`SYSBUS_LINE_OFFSET],
                        {`SYSBUS_LINE_OFFSET{1'b0}}};
                    rd_idx <= 3'd0;
                    rd_left <= 4'd8;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- include/sysbus_defs.svh
`ifndef SYSBUS_DEFS_SVH
`define SYSBUS_DEFS_SVH

// one bus word per beat, eight beats per 64-byte cache line.
`define SYSBUS_DATA_WIDTH 64
`define SYSBUS_LINE_BEATS 8
`define SYSBUS_LINE_WIDTH 512

// request tag is the command at bit 12 and the device code in bits 11 to 8.
`define SYSBUS_TAG_WIDTH 13
`define SYSBUS_WRITE 1'b1
`define SYSBUS_READ 1'b0
`define SYSBUS_MEMORY 4'h1

// low address bits cleared to point at the start of a line.
`define SYSBUS_LINE_OFFSET 6

`endif

//--- list.f
+incdir+include
src/sysbus_pkg.sv
src/line_store.sv
src/line_fetch.sv
src/bus_arbiter.sv
src/line_mover.sv
dv/sysbus_mem.sv
dv/line_mover_tb.sv

//--- run.sh
#!/bin/sh
# Builds the line mover testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module line_mover_tb \
    -Mdir obj_dir -o line_mover_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/line_mover_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi

//--- src/bus_arbiter.sv
`default_nettype none

module bus_arbiter
(
    input wire clk,
    input wire reset,
    input wire store_req,
    input wire fetch_req,
    input wire store_busy,
    input wire fetch_busy,
    output logic store_grant,
    output logic fetch_grant,
    output sysbus_pkg::bus_owner_t owner
);
    import sysbus_pkg::*;

    logic bus_free;
    logic store_keep;
    logic fetch_keep;
    bus_owner_t winner;

    assign bus_free = !store_grant && !fetch_grant;
    assign store_keep = store_busy || store_req;
    assign fetch_keep = fetch_busy || fetch_req;

    // owner keeps the last holder, so a tie goes to the other side.
    always_comb
    begin
        if (store_req && fetch_req)
            winner = (owner == OWNER_STORE) ? OWNER_FETCH : OWNER_STORE;
        else if (store_req)
            winner = OWNER_STORE;
        else
            winner = OWNER_FETCH;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            store_grant <= 1'b0;
            fetch_grant <= 1'b0;
            owner <= OWNER_FETCH;
        end
        else if (bus_free)
        begin
            if (store_req || fetch_req)
            begin
                owner <= winner;
                store_grant <= (winner == OWNER_STORE);
                fetch_grant <= (winner == OWNER_FETCH);
            end
        end
        else
        begin
            store_grant <= store_grant && store_keep;
            fetch_grant <= fetch_grant && fetch_keep;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        !(store_grant && fetch_grant))
        else $error("bus granted to both engines at once");

endmodule

`default_nettype wire

//--- src/line_fetch.sv
`default_nettype none

`include "sysbus_defs.svh"

module line_fetch
(
    input wire clk,
    input wire reset,
    input wire enable,
    input wire grant,
    input wire reqack,
    input wire respcyc,
    input wire [`SYSBUS_DATA_WIDTH-1:0] resp,
    input wire [`SYSBUS_DATA_WIDTH-1:0] addr,
    output logic abtr_reqcyc,
    output logic bus_busy,
    output logic reqcyc,
    output logic [`SYSBUS_DATA_WIDTH-1:0] req,
    output logic [`SYSBUS_TAG_WIDTH-1:0] reqtag,
    output logic respack,
    output logic [`SYSBUS_LINE_WIDTH-1:0] line,
    output logic ready
);
    import sysbus_pkg::*;

    localparam int CNT_W = $clog2(`SYSBUS_LINE_BEATS) + 1;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`SYSBUS_LINE_BEATS - 1);
    localparam bus_cmd_t CMD = CMD_READ;

    engine_state_t state;
    engine_state_t next_state;
    logic [CNT_W-1:0] beat_cnt;
    logic [CNT_W-2:0] word_idx;
    logic [`SYSBUS_DATA_WIDTH-1:0] addr_q;
    logic take;
    logic addr_done;
    logic resp_done;

    assign take = enable && (state == ST_IDLE || state == ST_READY);
    assign addr_done = reqcyc && reqack;
    assign resp_done = respcyc && respack;
    assign word_idx = beat_cnt[CNT_W-2:0];

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE, ST_READY:
                if (take)
                    next_state = ST_REQ_BUS;
            ST_REQ_BUS:
                if (grant)
                    next_state = ST_ADDR;
            ST_ADDR:
                if (addr_done)
                    next_state = ST_DATA;
            ST_DATA:
                if (resp_done && beat_cnt == LAST_BEAT)
                    next_state = ST_RELEASE;
            ST_RELEASE:
                next_state = ST_READY;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == ST_ADDR)
                beat_cnt <= '0;
            else if (resp_done)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // each accepted word lands in its slot, so the line holds until the next fetch fills it.
    always_ff @(posedge clk)
    begin
        if (take)
            addr_q <= addr;
        if (resp_done)
            line[word_idx*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] <= resp;
    end

    assign abtr_reqcyc = (state == ST_REQ_BUS);
    assign reqcyc = (state == ST_ADDR);
    assign respack = (state == ST_DATA);
    assign bus_busy = reqcyc || respack || (state == ST_RELEASE);
    assign ready = (state == ST_READY);
    assign reqtag = {CMD, `SYSBUS_MEMORY, {(`SYSBUS_TAG_WIDTH-5){1'b0}}};
    assign req = {addr_q[`SYSBUS_DATA_WIDTH-1:`SYSBUS_LINE_OFFSET], {`SYSBUS_LINE_OFFSET{1'b0}}};

    a_respack_granted: assert property (@(posedge clk) disable iff (reset)
        respack |-> grant)
        else $error("line_fetch accepts responses without owning the bus");

endmodule

`default_nettype wire

//--- src/line_mover.sv
`default_nettype none

`include "sysbus_defs.svh"

module line_mover
(
    input wire clk,
    input wire reset,
    input wire store_enable,
    input wire [`SYSBUS_DATA_WIDTH-1:0] store_addr,
    input wire [`SYSBUS_LINE_WIDTH-1:0] store_line,
    input wire fetch_enable,
    input wire [`SYSBUS_DATA_WIDTH-1:0] fetch_addr,
    input wire bus_reqack,
    input wire bus_respcyc,
    input wire [`SYSBUS_DATA_WIDTH-1:0] bus_resp,
    output logic store_ready,
    output logic fetch_ready,
    output logic [`SYSBUS_LINE_WIDTH-1:0] fetch_line,
    output logic bus_reqcyc,
    output logic [`SYSBUS_DATA_WIDTH-1:0] bus_req,
    output logic [`SYSBUS_TAG_WIDTH-1:0] bus_reqtag,
    output logic bus_respack,
    output logic bus_busy
);
    import sysbus_pkg::*;

    logic st_abtr_req;
    logic st_grant;
    logic st_busy;
    logic st_reqcyc;
    logic st_reqack;
    logic [`SYSBUS_DATA_WIDTH-1:0] st_req;
    logic [`SYSBUS_TAG_WIDTH-1:0] st_reqtag;
    logic fe_abtr_req;
    logic fe_grant;
    logic fe_busy;
    logic fe_reqcyc;
    logic fe_reqack;
    logic fe_respcyc;
    logic fe_respack;
    logic [`SYSBUS_DATA_WIDTH-1:0] fe_req;
    logic [`SYSBUS_DATA_WIDTH-1:0] fe_resp;
    logic [`SYSBUS_TAG_WIDTH-1:0] fe_reqtag;
    bus_owner_t owner;
    logic store_owns;

    assign store_owns = (owner == OWNER_STORE);

    // handshakes from the bus reach only the engine that owns it.
    assign st_reqack = bus_reqack && store_owns;
    assign fe_reqack = bus_reqack && !store_owns;
    assign fe_respcyc = bus_respcyc && !store_owns;
    assign fe_resp = store_owns ? '0 : bus_resp;

    assign bus_reqcyc = store_owns ? st_reqcyc : fe_reqcyc;
    assign bus_req = store_owns ? st_req : fe_req;
    assign bus_reqtag = store_owns ? st_reqtag : fe_reqtag;
    assign bus_respack = store_owns ? 1'b0 : fe_respack;
    assign bus_busy = st_busy | fe_busy;

    line_store u_line_store
    (
        .clk(clk), .reset(reset), .enable(store_enable), .grant(st_grant),
        .reqack(st_reqack), .addr(store_addr), .line(store_line),
        .abtr_reqcyc(st_abtr_req), .bus_busy(st_busy), .reqcyc(st_reqcyc),
        .req(st_req), .reqtag(st_reqtag), .ready(store_ready)
    );

    line_fetch u_line_fetch
    (
        .clk(clk), .reset(reset), .enable(fetch_enable), .grant(fe_grant),
        .reqack(fe_reqack), .respcyc(fe_respcyc), .resp(fe_resp), .addr(fetch_addr),
        .abtr_reqcyc(fe_abtr_req), .bus_busy(fe_busy), .reqcyc(fe_reqcyc),
        .req(fe_req), .reqtag(fe_reqtag), .respack(fe_respack),
        .line(fetch_line), .ready(fetch_ready)
    );

    bus_arbiter u_bus_arbiter
    (
        .clk(clk), .reset(reset), .store_req(st_abtr_req), .fetch_req(fe_abtr_req),
        .store_busy(st_busy), .fetch_busy(fe_busy), .store_grant(st_grant),
        .fetch_grant(fe_grant), .owner(owner)
    );

endmodule

`default_nettype wire

//--- src/line_store.sv
`default_nettype none

`include "sysbus_defs.svh"

module line_store
(
    input wire clk,
    input wire reset,
    input wire enable,
    input wire grant,
    input wire reqack,
    input wire [`SYSBUS_DATA_WIDTH-1:0] addr,
    input wire [`SYSBUS_LINE_WIDTH-1:0] line,
    output logic abtr_reqcyc,
    output logic bus_busy,
    output logic reqcyc,
    output logic [`SYSBUS_DATA_WIDTH-1:0] req,
    output logic [`SYSBUS_TAG_WIDTH-1:0] reqtag,
    output logic ready
);
    import sysbus_pkg::*;

    localparam int CNT_W = $clog2(`SYSBUS_LINE_BEATS) + 1;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`SYSBUS_LINE_BEATS - 1);
    localparam bus_cmd_t CMD = CMD_WRITE;

    engine_state_t state;
    engine_state_t next_state;
    logic [CNT_W-1:0] beat_cnt;
    logic [CNT_W-2:0] word_idx;
    logic [`SYSBUS_DATA_WIDTH-1:0] addr_q;
    logic [`SYSBUS_LINE_WIDTH-1:0] line_q;
    logic take;
    logic beat_done;

    assign take = enable && (state == ST_IDLE || state == ST_READY);
    assign beat_done = reqcyc && reqack;
    assign word_idx = beat_cnt[CNT_W-2:0];

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE, ST_READY:
                if (take)
                    next_state = ST_REQ_BUS;
            ST_REQ_BUS:
                if (grant)
                    next_state = ST_ADDR;
            ST_ADDR:
                if (beat_done)
                    next_state = ST_DATA;
            ST_DATA:
                if (beat_done && beat_cnt == LAST_BEAT)
                    next_state = ST_RELEASE;
            ST_RELEASE:
                next_state = ST_READY;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == ST_ADDR)
                beat_cnt <= '0;
            else if (state == ST_DATA && beat_done)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // the line is latched at enable so the client may change it during the burst.
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            addr_q <= addr;
            line_q <= line;
        end
    end

    assign abtr_reqcyc = (state == ST_REQ_BUS);
    assign reqcyc = (state == ST_ADDR) || (state == ST_DATA);
    assign bus_busy = reqcyc || (state == ST_RELEASE);
    assign ready = (state == ST_READY);
    assign reqtag = {CMD, `SYSBUS_MEMORY, {(`SYSBUS_TAG_WIDTH-5){1'b0}}};

    // word 0 sits in the low bits of the line and goes out first.
    assign req = (state == ST_DATA)
        ? line_q[word_idx*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH]
        : {addr_q[`SYSBUS_DATA_WIDTH-1:`SYSBUS_LINE_OFFSET], {`SYSBUS_LINE_OFFSET{1'b0}}};

    a_reqcyc_granted: assert property (@(posedge clk) disable iff (reset)
        reqcyc |-> grant)
        else $error("line_store drives reqcyc without a bus grant");

    a_beat_cnt_bound: assert property (@(posedge clk) disable iff (reset)
        beat_cnt <= CNT_W'(`SYSBUS_LINE_BEATS))
        else $error("line_store beat counter ran past a full line");

endmodule

`default_nettype wire

//--- src/sysbus_pkg.sv
`default_nettype none

`include "sysbus_defs.svh"

package sysbus_pkg;

    // shared sequence of both line engines.
    typedef enum logic [2:0]
    {
        ST_IDLE    = 3'd0,
        ST_REQ_BUS = 3'd1,
        ST_ADDR    = 3'd2,
        ST_DATA    = 3'd3,
        ST_RELEASE = 3'd4,
        ST_READY   = 3'd5
    } engine_state_t;

    typedef enum logic
    {
        OWNER_STORE = 1'b0,
        OWNER_FETCH = 1'b1
    } bus_owner_t;

    typedef enum logic
    {
        CMD_READ  = `SYSBUS_READ,
        CMD_WRITE = `SYSBUS_WRITE
    } bus_cmd_t;

endpackage

`default_nettype wire
